//--- tb.f
verilog/afifo_pkg.sv
verilog/chan_fifo.sv
verilog/write_router.sv
verilog/rr_drain.sv
verilog/fifo_bank.sv
tests/tb_clock.sv
tests/tb_fifo_bank.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_fifo_bank -f tb.f -o sim_tb; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
   exit 0
fi
exit 1

//--- tests/tb_fifo_bank.sv
module tb_fifo_bank
   import afifo_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESET_CYCLES = 3;
   localparam int RAND_CYCLES = 400;
   localparam int DRAIN_LIMIT = 200;
   localparam int STIM_CYCLES = RESET_CYCLES + 6 * (FIFO_DEPTH + 8) + RAND_CYCLES
                                + 6 * DRAIN_LIMIT;
   localparam int SEQ_W = DATA_W - CHAN_W;

   logic       rd_clk;
   logic       rst;
   logic       wr_en;
   chan_t      wr_chan;
   data_t      wr_data;
   logic       drain_en;
   logic       out_valid;
   chan_t      out_chan;
   data_t      out_data;
   chan_mask_t full;
   chan_mask_t almost_full;
   cnt_t       drop_count;

   // reference model with one queue per channel
   data_t            model_q [NUM_CHAN][$];
   logic [SEQ_W-1:0] seq_num [NUM_CHAN];
   int               exp_drops;
   chan_t            rr_exp;
   chan_t            exp_ch;
   logic             check_order;
   logic             order_started;

   int     errors;
   int     checks;
   integer seed;

   tb_clock clock0 (.rd_clk(rd_clk));

   fifo_bank dut0 (
      .rd_clk      (rd_clk),
      .rst         (rst),
      .wr_en       (wr_en),
      .wr_chan     (wr_chan),
      .wr_data     (wr_data),
      .drain_en    (drain_en),
      .out_valid   (out_valid),
      .out_chan    (out_chan),
      .out_data    (out_data),
      .full        (full),
      .almost_full (almost_full),
      .drop_count  (drop_count)
   );

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAIL at %0t: %s got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   function automatic int pending_words();
      int total;
      total = 0;
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         total += model_q[c].size();
      end
      return total;
   endfunction

   // first non-empty channel from the round-robin start
   function automatic chan_t next_channel();
      chan_t c;
      c = rr_exp;
      for (int i = 0; i < NUM_CHAN; i++)
      begin
         if (model_q[c].size() != 0)
         begin
            return c;
         end
         c = c + 1'b1;
      end
      return rr_exp;
   endfunction

   // channel on top and sequence number below
   task automatic write_word(input chan_t ch);
      data_t word;
      word = {ch, seq_num[ch]};
      seq_num[ch] = seq_num[ch] + 1'b1;
      if (model_q[ch].size() < FIFO_DEPTH)
      begin
         model_q[ch].push_back(word);
      end
      else
      begin
         exp_drops++;
      end
      wr_en = 1'b1;
      wr_chan = ch;
      wr_data = word;
      @(negedge rd_clk);
   endtask

   task automatic idle_cycles(input int n);
      wr_en = 1'b0;
      repeat (n) @(negedge rd_clk);
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      wr_en = 1'b0;
      while (pending_words() != 0 && n < DRAIN_LIMIT)
      begin
         @(negedge rd_clk);
         n++;
      end
      if (pending_words() != 0)
      begin
         errors++;
         $display("error at %0t: %0d accepted words never came out", $time, pending_words());
      end
      // room for stray output words
      repeat (4) @(negedge rd_clk);
   endtask

   task automatic watch_outputs();
      forever
      begin
         @(negedge rd_clk);
         if (!check_order)
         begin
            order_started = 1'b0;
         end
         else if (out_valid)
         begin
            order_started = 1'b1;
         end
         else if (order_started && pending_words() != 0)
         begin
            errors++;
            $display("error at %0t: gap in the output stream while words wait", $time);
         end
         if (out_valid)
         begin
            if (model_q[out_chan].size() == 0)
            begin
               errors++;
               $display("error at %0t: output word on channel %0d with no write behind it",
                        $time, out_chan);
            end
            else
            begin
               if (check_order)
               begin
                  exp_ch = next_channel();
                  check_value("out_chan", 64'(out_chan), 64'(exp_ch));
                  rr_exp = exp_ch + 1'b1;
               end
               check_value("out_data", 64'(out_data), 64'(model_q[out_chan][0]));
               void'(model_q[out_chan].pop_front());
            end
         end
      end
   endtask

   //////////////////////////////////////////////////
   // test phases
   //////////////////////////////////////////////////

   task automatic fill_and_check(input chan_t ch);
      int drops_before;
      drops_before = exp_drops;
      drain_en = 1'b0;
      repeat (FIFO_DEPTH - 2) write_word(ch);
      idle_cycles(2);
      check_value("almost_full at depth-2", 64'(almost_full[ch]), 64'd1);
      check_value("full at depth-2", 64'(full[ch]), 64'd0);
      repeat (2) write_word(ch);
      idle_cycles(2);
      check_value("full at depth", 64'(full[ch]), 64'd1);
      check_value("drop_count at depth", 64'(drop_count), 64'(drops_before));
      repeat (3) write_word(ch);
      idle_cycles(2);
      check_value("drop_count after overflow", 64'(drop_count), 64'(drops_before + 3));
   endtask

   task automatic drain_and_check_clear(input chan_t ch);
      check_order = 1'b1;
      drain_en = 1'b1;
      wait_drained();
      check_order = 1'b0;
      drain_en = 1'b0;
      check_value("full after drain", 64'(full[ch]), 64'd0);
      check_value("almost_full after drain", 64'(almost_full[ch]), 64'd0);
   endtask

   task automatic round_robin_order();
      drain_en = 1'b0;
      repeat (5) write_word(chan_t'(0));
      repeat (3) write_word(chan_t'(2));
      repeat (7) write_word(chan_t'(3));
      idle_cycles(3);
      check_order = 1'b1;
      drain_en = 1'b1;
      wait_drained();
      check_order = 1'b0;
      drain_en = 1'b0;
   endtask

   // about one word every two cycles so the drain keeps up
   task automatic random_traffic();
      chan_t ch;
      drain_en = 1'b1;
      for (int n = 0; n < RAND_CYCLES; n++)
      begin
         ch = chan_t'($random(seed));
         if (($random(seed) & 1) == 1)
         begin
            write_word(ch);
         end
         else
         begin
            idle_cycles(1);
         end
      end
      wait_drained();
      check_value("drop_count after random traffic", 64'(drop_count), 64'(exp_drops));
      drain_en = 1'b0;
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////

   initial
   begin
      seed = 76368;
      errors = 0;
      checks = 0;
      exp_drops = 0;
      rr_exp = '0;
      exp_ch = '0;
      check_order = 1'b0;
      order_started = 1'b0;
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         seq_num[c] = '0;
      end
      rst = 1'b1;
      wr_en = 1'b0;
      wr_chan = '0;
      wr_data = '0;
      drain_en = 1'b0;
      repeat (RESET_CYCLES) @(negedge rd_clk);
      rst = 1'b0;

      check_value("out_valid after reset", 64'(out_valid), 64'd0);
      check_value("full after reset", 64'(full), 64'd0);
      check_value("almost_full after reset", 64'(almost_full), 64'd0);
      check_value("drop_count after reset", 64'(drop_count), 64'd0);

      fork
         watch_outputs();
      join_none

      fill_and_check(chan_t'(0));
      drain_and_check_clear(chan_t'(0));
      round_robin_order();
      random_traffic();

      // full recovery on one channel
      fill_and_check(chan_t'(1));
      drain_and_check_clear(chan_t'(1));
      fill_and_check(chan_t'(1));
      drain_and_check_clear(chan_t'(1));

      check_value("words left in model", 64'(pending_words()), 64'd0);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display(">>> PASS");
      end
      else
      begin
         $display(">>> FAIL");
      end
      $finish;
   end

   // watchdog
   initial
   begin
      #(STIM_CYCLES * 10 + 1000);
      $display("timeout: run did not finish within %0d cycles", STIM_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

endmodule

//--- tests/tb_clock.sv
module tb_clock
(
   output logic rd_clk
);

   timeunit 1ns;
   timeprecision 1ps;

   // 10 ns period
   initial
   begin
      rd_clk = 1'b0;
      forever
      begin
         #5 rd_clk = ~rd_clk;
      end
   end

endmodule

//--- verilog/fifo_bank.sv
module fifo_bank
   import afifo_pkg::*;
(
   input  logic       rd_clk,
   input  logic       rst,
   input  logic       wr_en,
   input  chan_t      wr_chan,
   input  data_t      wr_data,
   input  logic       drain_en,
   output logic       out_valid,
   output chan_t      out_chan,
   output data_t      out_data,
   output chan_mask_t full,
   output chan_mask_t almost_full,
   output cnt_t       drop_count
);

   // router to channel FIFOs
   chan_mask_t push;
   data_t      push_data;

   // channel FIFOs to drain
   chan_mask_t empty;
   chan_mask_t pop;
   data_t      rd_data [NUM_CHAN];

   //////////////////////////////////////////////////
   // write side
   //////////////////////////////////////////////////

   write_router router0 (
      .rd_clk     (rd_clk),
      .rst        (rst),
      .wr_en      (wr_en),
      .wr_chan    (wr_chan),
      .wr_data    (wr_data),
      .full       (full),
      .push       (push),
      .push_data  (push_data),
      .drop_count (drop_count)
   );

   //////////////////////////////////////////////////
   // channel FIFOs
   //////////////////////////////////////////////////

   for (genvar g = 0; g < NUM_CHAN; g++)
   begin : g_chan
      chan_fifo fifo0 (
         .rd_clk      (rd_clk),
         .rst         (rst),
         .push        (push[g]),
         .push_data   (push_data),
         .pop         (pop[g]),
         .rd_data     (rd_data[g]),
         .empty       (empty[g]),
         .full        (full[g]),
         .almost_full (almost_full[g])
      );
   end

   //////////////////////////////////////////////////
   // read side
   //////////////////////////////////////////////////

   rr_drain drain0 (
      .rd_clk    (rd_clk),
      .rst       (rst),
      .drain_en  (drain_en),
      .empty     (empty),
      .fifo_data (rd_data),
      .pop       (pop),
      .out_valid (out_valid),
      .out_chan  (out_chan),
      .out_data  (out_data)
   );

endmodule

//--- verilog/rr_drain.sv
module rr_drain
   import afifo_pkg::*;
(
   input  logic       rd_clk,
   input  logic       rst,
   input  logic       drain_en,
   input  chan_mask_t empty,
   input  data_t      fifo_data [NUM_CHAN],
   output chan_mask_t pop,
   output logic       out_valid,
   output chan_t      out_chan,
   output data_t      out_data
);

   // first channel to try is one past the last served
   chan_t rr_ptr;

   chan_t sel;
   logic  found;
   logic  take;

   //////////////////////////////////////////////////
   // arbitration
   //////////////////////////////////////////////////

   // index math wraps naturally since NUM_CHAN is 2**CHAN_W
   always_comb
   begin
      found = 1'b0;
      sel   = rr_ptr;
      for (int i = 0; i < NUM_CHAN; i++)
      begin
         if (!found && !empty[rr_ptr + chan_t'(i)])
         begin
            found = 1'b1;
            sel   = rr_ptr + chan_t'(i);
         end
      end
   end

   assign take = drain_en && found;

   always_comb
   begin
      pop = '0;
      if (take)
      begin
         pop[sel] = 1'b1;
      end
   end

   // only moves on a real pop
   always_ff @(posedge rd_clk)
   begin
      if (rst)
      begin
         rr_ptr <= '0;
      end
      else if (take)
      begin
         rr_ptr <= sel + chan_t'(1);
      end
   end

   //////////////////////////////////////////////////
   // output register
   //////////////////////////////////////////////////

   always_ff @(posedge rd_clk)
   begin
      if (rst)
      begin
         out_valid <= 1'b0;
      end
      else
      begin
         out_valid <= take;
      end
   end

   // head word is sampled in the pop cycle
   always_ff @(posedge rd_clk)
   begin
      if (take)
      begin
         out_chan <= sel;
         out_data <= fifo_data[sel];
      end
   end

endmodule

//--- verilog/write_router.sv
module write_router
   import afifo_pkg::*;
(
   input  logic       rd_clk,
   input  logic       rst,
   input  logic       wr_en,
   input  chan_t      wr_chan,
   input  data_t      wr_data,
   input  chan_mask_t full,
   output chan_mask_t push,
   output data_t      push_data,
   output cnt_t       drop_count
);

   // held write from the previous cycle
   logic  held_valid;
   chan_t held_chan;
   data_t held_data;

   logic drop;

   //////////////////////////////////////////////////
   // input stage
   //////////////////////////////////////////////////

   always_ff @(posedge rd_clk)
   begin
      if (rst)
      begin
         held_valid <= 1'b0;
      end
      else
      begin
         held_valid <= wr_en;
      end
   end

   always_ff @(posedge rd_clk)
   begin
      held_chan <= wr_chan;
      held_data <= wr_data;
   end

   assign push_data = held_data;

   //////////////////////////////////////////////////
   // steering
   //////////////////////////////////////////////////

   // full flag is checked in the push cycle itself
   always_comb
   begin
      push = '0;
      drop = 1'b0;
      if (held_valid)
      begin
         if (full[held_chan])
         begin
            drop = 1'b1;
         end
         else
         begin
            push[held_chan] = 1'b1;
         end
      end
   end

   // saturates at all ones
   always_ff @(posedge rd_clk)
   begin
      if (rst)
      begin
         drop_count <= '0;
      end
      else if (drop && (drop_count != '1))
      begin
         drop_count <= drop_count + cnt_t'(1);
      end
   end

endmodule

//--- verilog/chan_fifo.sv
module chan_fifo
   import afifo_pkg::*;
(
   input  logic  rd_clk,
   input  logic  rst,
   input  logic  push,
   input  data_t push_data,
   input  logic  pop,
   output data_t rd_data,
   output logic  empty,
   output logic  full,
   output logic  almost_full
);

   data_t mem [FIFO_DEPTH];

   ptr_t wr_ptr;
   ptr_t rd_ptr;

   // occupancy now and after this cycle's push/pop
   ptr_t fill;
   ptr_t fill_next;

   logic [ADDR_W-1:0] wr_addr;
   logic [ADDR_W-1:0] rd_addr;

   //////////////////////////////////////////////////
   // storage
   //////////////////////////////////////////////////

   assign wr_addr = wr_ptr[ADDR_W-1:0];
   assign rd_addr = rd_ptr[ADDR_W-1:0];

   // head word is always visible
   assign rd_data = mem[rd_addr];

   always_ff @(posedge rd_clk)
   begin
      if (push)
      begin
         mem[wr_addr] <= push_data;
      end
   end

   //////////////////////////////////////////////////
   // pointers
   //////////////////////////////////////////////////

   always_ff @(posedge rd_clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= wr_ptr + ptr_t'(1);
         end
         if (pop)
         begin
            rd_ptr <= rd_ptr + ptr_t'(1);
         end
      end
   end

   // wrap bit makes the plain difference exact up to FIFO_DEPTH
   assign fill = wr_ptr - rd_ptr;
   assign fill_next = fill + ptr_t'(push) - ptr_t'(pop);

   //////////////////////////////////////////////////
   // flags
   //////////////////////////////////////////////////

   // empty tracks both sides, so it clears right after the first push
   always_ff @(posedge rd_clk)
   begin
      if (rst)
      begin
         empty <= 1'b1;
      end
      else
      begin
         empty <= (fill_next == '0);
      end
   end

   // full side looks ahead at push only
   always_ff @(posedge rd_clk)
   begin
      if (rst)
      begin
         full        <= 1'b0;
         almost_full <= 1'b0;
      end
      else
      begin
         full <= (fill == ptr_t'(FIFO_DEPTH)) ||
                 ((fill == ptr_t'(FIFO_DEPTH-1)) && push);
         almost_full <= (fill >= ptr_t'(FIFO_DEPTH-2)) ||
                        ((fill == ptr_t'(FIFO_DEPTH-3)) && push);
      end
   end

endmodule

//--- verilog/afifo_pkg.sv
package afifo_pkg;

   //////////////////////////////////////////////////
   // bank geometry
   //////////////////////////////////////////////////

   // channel count must stay a power of two
   localparam int NUM_CHAN = 4;
   localparam int CHAN_W = 2;

   // word width
   localparam int DATA_W = 32;

   // per channel FIFO size
   localparam int FIFO_DEPTH = 16;
   localparam int ADDR_W = 4;

   // drop counter width
   localparam int CNT_W = 16;

   //////////////////////////////////////////////////
   // shared vector types
   //////////////////////////////////////////////////

   typedef logic [DATA_W-1:0] data_t;

   typedef logic [CHAN_W-1:0] chan_t;

   // address plus wrap bit
   typedef logic [ADDR_W:0] ptr_t;

   typedef logic [CNT_W-1:0] cnt_t;

   // one bit per channel
   typedef logic [NUM_CHAN-1:0] chan_mask_t;

endpackage
